// File: include/spi_xip_cfg.svh
`ifndef SPI_XIP_CFG_SVH
`define SPI_XIP_CFG_SVH

// Flash window, XIP reads only
`define SPI_FLASH_BASE 32'h3000_0000
`define SPI_FLASH_LAST 32'h3fff_ffff

// SPI master register window
`define SPI_MASTER_BASE 32'h1000_1000
`define SPI_MASTER_LAST 32'h1000_1fff

// Number of slave select lines
`define SPI_SS_NUM 8

// Divider the sequencer programs before a flash read
// sck period is 2*(divider+1) clocks
`define SPI_XIP_DIVIDER 16'd1

`endif

// File: hw/spi_xip_pkg.sv
`default_nettype none

`include "spi_xip_cfg.svh"

package spi_xip_pkg;

  typedef logic [31:0] apb_addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [`SPI_SS_NUM-1:0] ss_t;
  typedef logic [15:0] divider_t;
  typedef logic [6:0] char_len_t;

  // Register offsets, one word each
  localparam reg_addr_t REG_DATA0 = 5'h00;
  localparam reg_addr_t REG_DATA1 = 5'h04;
  localparam reg_addr_t REG_CTRL = 5'h10;
  localparam reg_addr_t REG_DIVIDER = 5'h14;
  localparam reg_addr_t REG_SS = 5'h18;

  // CTRL fields besides char_len in 6..0
  localparam int CTRL_GO_BIT = 8;
  localparam int CTRL_IE_BIT = 12;

  // Internal register bus, strobe held until ack
  typedef struct packed {
    reg_addr_t addr;
    data_t wdata;
    strb_t be;
    logic we;
    logic stb;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic ack;
    logic err;
  } reg_rsp_t;

  // Register bank to shift engine
  typedef struct packed {
    logic [63:0] tx;
    char_len_t char_len;
    divider_t divider;
    logic go;
  } shift_cmd_t;

  typedef struct packed {
    logic busy;
    logic done;
    logic [63:0] rx;
  } shift_sts_t;

  typedef enum logic [3:0] {
    IDLE,
    SEND_CMD,
    SET_DIVIDER,
    SET_SS,
    GO_BUSY,
    WAIT_COMPLETE,
    CLEAR_SS,
    READ_DATA,
    DONE
  } xip_state_e;

endpackage

`default_nettype wire

// File: hw/spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine (
  input  logic                    clock,
  input  logic                    reset,
  input  spi_xip_pkg::shift_cmd_t shift_cmd_i,
  output spi_xip_pkg::shift_sts_t shift_sts_o,
  input  spi_xip_pkg::ss_t        ss_i,
  output logic                    spi_sck_o,
  output spi_xip_pkg::ss_t        spi_ss_o,
  output logic                    spi_mosi_o,
  input  logic                    spi_miso_i
);

  // Length clamped to 1..64, zero means 64
  spi_xip_pkg::char_len_t len;
  // Left shift that puts the first bit at the top
  spi_xip_pkg::char_len_t align;
  spi_xip_pkg::divider_t div_q;
  spi_xip_pkg::divider_t cnt_q;
  spi_xip_pkg::char_len_t bits_q;
  logic [63:0] shreg_q;
  logic busy_q;
  logic done_q;
  logic sck_q;
  logic miso_q;
  // Half period elapsed
  logic tick;

  assign len = (shift_cmd_i.char_len == '0 || shift_cmd_i.char_len > 7'd64) ?
               7'd64 : shift_cmd_i.char_len;
  assign align = 7'd64 - len;
  assign tick = busy_q && (cnt_q == '0);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      sck_q <= 1'b0;
      div_q <= '0;
      cnt_q <= '0;
      bits_q <= '0;
      shreg_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (shift_cmd_i.go) begin
          // Divider latched so a rewrite mid transfer has no effect
          busy_q <= 1'b1;
          sck_q <= 1'b0;
          div_q <= shift_cmd_i.divider;
          cnt_q <= shift_cmd_i.divider;
          bits_q <= len;
          shreg_q <= shift_cmd_i.tx << align;
        end
      end else if (tick) begin
        cnt_q <= div_q;
        sck_q <= ~sck_q;
        // Falling edge, next bit out and sampled bit in
        if (sck_q) begin
          shreg_q <= {shreg_q[62:0], miso_q};
          bits_q <= bits_q - 7'd1;
          if (bits_q == 7'd1) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end else begin
        cnt_q <= cnt_q - 16'd1;
      end
    end
  end

  // miso taken as sck rises
  always_ff @(posedge clock) begin
    if (tick && !sck_q) begin
      miso_q <= spi_miso_i;
    end
  end

  assign shift_sts_o = '{busy: busy_q, done: done_q, rx: shreg_q};
  assign spi_sck_o = sck_q;
  assign spi_mosi_o = shreg_q[63];
  // Selects are active low on the pads
  assign spi_ss_o = ~ss_i;

endmodule

`default_nettype wire

// File: hw/spi_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank (
  input  logic                    clock,
  input  logic                    reset,
  input  spi_xip_pkg::reg_req_t   reg_req_i,
  output spi_xip_pkg::reg_rsp_t   reg_rsp_o,
  output spi_xip_pkg::shift_cmd_t shift_cmd_o,
  input  spi_xip_pkg::shift_sts_t shift_sts_i,
  output spi_xip_pkg::ss_t        ss_o,
  output logic                    irq_o
);

  // TX1 in the upper half, sent first
  logic [63:0] tx_q;
  logic [63:0] rx_q;
  spi_xip_pkg::char_len_t char_len_q;
  spi_xip_pkg::divider_t divider_q;
  spi_xip_pkg::ss_t ss_q;
  logic ie_q;
  logic irq_q;
  logic go_q;
  logic ack_q;
  logic err_q;
  spi_xip_pkg::data_t rdata_q;

  logic accept;
  logic hit;
  logic busy;
  spi_xip_pkg::data_t ctrl_word;
  spi_xip_pkg::data_t rd_word;
  spi_xip_pkg::data_t wr_base;
  spi_xip_pkg::data_t wr_word;

  // Byte lane merge of a write into the current value
  function automatic spi_xip_pkg::data_t merge_be(spi_xip_pkg::data_t old_w,
                                                  spi_xip_pkg::data_t new_w,
                                                  spi_xip_pkg::strb_t be);
    spi_xip_pkg::data_t res;
    for (int i = 0; i < 4; i++) begin
      res[8*i +: 8] = be[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
    end
    return res;
  endfunction

  // New request only when no response is pending
  assign accept = reg_req_i.stb && !ack_q && !err_q;
  // Busy also covers the go cycle before the engine reacts
  assign busy = shift_sts_i.busy || go_q;
  assign ctrl_word = {19'b0, ie_q, 3'b0, busy, 1'b0, char_len_q};

  // Offset decode, readback and write base
  always_comb begin
    hit = 1'b1;
    rd_word = '0;
    wr_base = '0;
    case (reg_req_i.addr)
      spi_xip_pkg::REG_DATA0: begin
        rd_word = rx_q[31:0];
        wr_base = tx_q[31:0];
      end
      spi_xip_pkg::REG_DATA1: begin
        rd_word = rx_q[63:32];
        wr_base = tx_q[63:32];
      end
      spi_xip_pkg::REG_CTRL: begin
        rd_word = ctrl_word;
        wr_base = ctrl_word;
      end
      spi_xip_pkg::REG_DIVIDER: begin
        rd_word = 32'(divider_q);
        wr_base = rd_word;
      end
      spi_xip_pkg::REG_SS: begin
        rd_word = 32'(ss_q);
        wr_base = rd_word;
      end
      default: begin
        hit = 1'b0;
      end
    endcase
  end

  assign wr_word = merge_be(wr_base, reg_req_i.wdata, reg_req_i.be);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx_q <= '0;
      char_len_q <= '0;
      divider_q <= '0;
      ss_q <= '0;
      ie_q <= 1'b0;
      irq_q <= 1'b0;
      go_q <= 1'b0;
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      go_q <= 1'b0;
      ack_q <= accept && hit;
      err_q <= accept && !hit;
      if (accept && hit && reg_req_i.addr == spi_xip_pkg::REG_CTRL) begin
        irq_q <= 1'b0;
      end
      // Sticky until the next CTRL access
      if (shift_sts_i.done && ie_q) begin
        irq_q <= 1'b1;
      end
      if (accept && hit && reg_req_i.we) begin
        case (reg_req_i.addr)
          spi_xip_pkg::REG_DATA0: tx_q[31:0] <= wr_word;
          spi_xip_pkg::REG_DATA1: tx_q[63:32] <= wr_word;
          spi_xip_pkg::REG_CTRL: begin
            char_len_q <= wr_word[6:0];
            ie_q <= wr_word[spi_xip_pkg::CTRL_IE_BIT];
            // go dropped while a transfer runs
            go_q <= wr_word[spi_xip_pkg::CTRL_GO_BIT] && !busy;
          end
          spi_xip_pkg::REG_DIVIDER: divider_q <= spi_xip_pkg::divider_t'(wr_word);
          default: ss_q <= spi_xip_pkg::ss_t'(wr_word);
        endcase
      end
    end
  end

  // Read data goes out with ack
  always_ff @(posedge clock) begin
    if (accept && hit) begin
      rdata_q <= rd_word;
    end
    if (shift_sts_i.done) begin
      rx_q <= shift_sts_i.rx;
    end
  end

  assign reg_rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};
  assign shift_cmd_o = '{tx: tx_q, char_len: char_len_q, divider: divider_q, go: go_q};
  assign ss_o = ss_q;
  assign irq_o = irq_q;

endmodule

`default_nettype wire

// File: hw/spi_apb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_xip_cfg.svh"

module spi_apb_bridge (
  input  logic                   clock,
  input  logic                   reset,
  input  spi_xip_pkg::apb_addr_t in_paddr_i,
  input  logic                   in_psel_i,
  input  logic                   in_penable_i,
  input  logic                   in_pwrite_i,
  input  spi_xip_pkg::data_t     in_pwdata_i,
  input  spi_xip_pkg::strb_t     in_pstrb_i,
  output logic                   in_pready_o,
  output spi_xip_pkg::data_t     in_prdata_o,
  output logic                   in_pslverr_o,
  output spi_xip_pkg::reg_req_t  reg_req_o,
  input  spi_xip_pkg::reg_rsp_t  reg_rsp_i
);

  // Address decode
  logic is_flash;
  logic is_master;
  // APB access phase
  logic access;

  // Sequencer state and its bus request
  spi_xip_pkg::xip_state_e state_q;
  spi_xip_pkg::xip_state_e seq_next;
  spi_xip_pkg::reg_req_t seq_req;
  spi_xip_pkg::reg_req_t direct_req;
  logic stb_q;
  // Word returned to APB after an XIP read
  spi_xip_pkg::data_t xip_data_q;

  assign is_flash = (in_paddr_i >= `SPI_FLASH_BASE) && (in_paddr_i <= `SPI_FLASH_LAST);
  assign is_master = (in_paddr_i >= `SPI_MASTER_BASE) && (in_paddr_i <= `SPI_MASTER_LAST);
  assign access = in_psel_i && in_penable_i;

  // Direct path, APB fields forwarded as they are
  // Strobe only in the access phase, so the bank acks one cycle later
  always_comb begin
    direct_req.addr = in_paddr_i[4:0];
    direct_req.wdata = in_pwdata_i;
    direct_req.be = in_pwrite_i ? in_pstrb_i : 4'h0;
    direct_req.we = in_pwrite_i;
    direct_req.stb = access && is_master;
  end

  // One register access per sequencer state
  // Fields depend on state only and stay stable until ack
  always_comb begin
    seq_req = '0;
    seq_next = state_q;
    case (state_q)
      spi_xip_pkg::SEND_CMD: begin
        // Read command in the top byte of TX1, shifted out first
        seq_req.addr = spi_xip_pkg::REG_DATA1;
        seq_req.wdata = {8'h03, in_paddr_i[23:0]};
        seq_req.we = 1'b1;
        seq_next = spi_xip_pkg::SET_DIVIDER;
      end
      spi_xip_pkg::SET_DIVIDER: begin
        seq_req.addr = spi_xip_pkg::REG_DIVIDER;
        seq_req.wdata = 32'(`SPI_XIP_DIVIDER);
        seq_req.we = 1'b1;
        seq_next = spi_xip_pkg::SET_SS;
      end
      spi_xip_pkg::SET_SS: begin
        // Flash sits on select line 0
        seq_req.addr = spi_xip_pkg::REG_SS;
        seq_req.wdata = 32'h0000_0001;
        seq_req.we = 1'b1;
        seq_next = spi_xip_pkg::GO_BUSY;
      end
      spi_xip_pkg::GO_BUSY: begin
        // go plus char_len 64, command and data in one transfer
        seq_req.addr = spi_xip_pkg::REG_CTRL;
        seq_req.wdata = 32'h0000_0140;
        seq_req.we = 1'b1;
        seq_next = spi_xip_pkg::WAIT_COMPLETE;
      end
      spi_xip_pkg::WAIT_COMPLETE: begin
        // Poll again while the busy bit reads back set
        seq_req.addr = spi_xip_pkg::REG_CTRL;
        seq_next = reg_rsp_i.rdata[spi_xip_pkg::CTRL_GO_BIT] ?
                   spi_xip_pkg::WAIT_COMPLETE : spi_xip_pkg::CLEAR_SS;
      end
      spi_xip_pkg::CLEAR_SS: begin
        seq_req.addr = spi_xip_pkg::REG_SS;
        seq_req.we = 1'b1;
        seq_next = spi_xip_pkg::READ_DATA;
      end
      spi_xip_pkg::READ_DATA: begin
        // RX0 holds the last 32 bits shifted in
        seq_req.addr = spi_xip_pkg::REG_DATA0;
        seq_next = spi_xip_pkg::DONE;
      end
      default: begin
        seq_next = state_q;
      end
    endcase
    seq_req.be = seq_req.we ? 4'hf : 4'h0;
    seq_req.stb = stb_q;
  end

  // The APB address is held for the whole transfer, so it picks the owner
  assign reg_req_o = is_flash ? seq_req : direct_req;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= spi_xip_pkg::IDLE;
      stb_q <= 1'b0;
    end else begin
      case (state_q)
        spi_xip_pkg::IDLE: begin
          if (access && is_flash) begin
            state_q <= spi_xip_pkg::SEND_CMD;
          end
        end
        spi_xip_pkg::DONE: begin
          // Hold pready until the master closes the access phase
          if (!in_penable_i) begin
            state_q <= spi_xip_pkg::IDLE;
          end
        end
        default: begin
          // Raise stb, then drop it the cycle after ack
          if (!stb_q) begin
            stb_q <= 1'b1;
          end else if (reg_rsp_i.ack) begin
            stb_q <= 1'b0;
            state_q <= seq_next;
          end
        end
      endcase
    end
  end

  // Latched so prdata stays stable through DONE
  always_ff @(posedge clock) begin
    if (state_q == spi_xip_pkg::READ_DATA && stb_q && reg_rsp_i.ack) begin
      xip_data_q <= reg_rsp_i.rdata;
    end
  end

  // APB response mux
  always_comb begin
    in_prdata_o = reg_rsp_i.rdata;
    if (is_flash) begin
      in_pready_o = (state_q == spi_xip_pkg::DONE);
      in_pslverr_o = 1'b0;
      in_prdata_o = xip_data_q;
    end else if (is_master) begin
      in_pready_o = reg_rsp_i.ack || reg_rsp_i.err;
      in_pslverr_o = reg_rsp_i.err;
    end else begin
      // Unmapped, error in the first access cycle
      in_pready_o = access;
      in_pslverr_o = access;
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_xip_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_xip_top (
  input  logic                   clock,
  input  logic                   reset,
  input  spi_xip_pkg::apb_addr_t in_paddr_i,
  input  logic                   in_psel_i,
  input  logic                   in_penable_i,
  input  logic                   in_pwrite_i,
  input  spi_xip_pkg::data_t     in_pwdata_i,
  input  spi_xip_pkg::strb_t     in_pstrb_i,
  output logic                   in_pready_o,
  output spi_xip_pkg::data_t     in_prdata_o,
  output logic                   in_pslverr_o,
  output logic                   spi_sck_o,
  output spi_xip_pkg::ss_t       spi_ss_o,
  output logic                   spi_mosi_o,
  input  logic                   spi_miso_i,
  output logic                   spi_irq_o
);

  // Register bus, bridge to bank
  spi_xip_pkg::reg_req_t reg_req;
  spi_xip_pkg::reg_rsp_t reg_rsp;
  // Bank to shift engine and back
  spi_xip_pkg::shift_cmd_t shift_cmd;
  spi_xip_pkg::shift_sts_t shift_sts;
  spi_xip_pkg::ss_t ss;

  spi_apb_bridge i_spi_apb_bridge (
    .clock        (clock),
    .reset        (reset),
    .in_paddr_i   (in_paddr_i),
    .in_psel_i    (in_psel_i),
    .in_penable_i (in_penable_i),
    .in_pwrite_i  (in_pwrite_i),
    .in_pwdata_i  (in_pwdata_i),
    .in_pstrb_i   (in_pstrb_i),
    .in_pready_o  (in_pready_o),
    .in_prdata_o  (in_prdata_o),
    .in_pslverr_o (in_pslverr_o),
    .reg_req_o    (reg_req),
    .reg_rsp_i    (reg_rsp)
  );

  spi_reg_bank i_spi_reg_bank (
    .clock       (clock),
    .reset       (reset),
    .reg_req_i   (reg_req),
    .reg_rsp_o   (reg_rsp),
    .shift_cmd_o (shift_cmd),
    .shift_sts_i (shift_sts),
    .ss_o        (ss),
    .irq_o       (spi_irq_o)
  );

  spi_shift_engine i_spi_shift_engine (
    .clock       (clock),
    .reset       (reset),
    .shift_cmd_i (shift_cmd),
    .shift_sts_o (shift_sts),
    .ss_i        (ss),
    .spi_sck_o   (spi_sck_o),
    .spi_ss_o    (spi_ss_o),
    .spi_mosi_o  (spi_mosi_o),
    .spi_miso_i  (spi_miso_i)
  );

endmodule

`default_nettype wire

// File: test/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model #(
  parameter int WORDS = 1024
) (
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  localparam int IDX_W = $clog2(WORDS);

  logic [31:0] mem [WORDS];
  // Command byte and address as received, MSB first
  logic [31:0] cmd_q;
  logic [31:0] cmd_next;
  // Rising edges seen since select
  logic [6:0] bit_cnt;
  // Word being returned for a read command
  logic [31:0] rd_word;
  logic rd_active;

  // Preload by byte offset into the flash
  task automatic load_word(input logic [23:0] addr, input logic [31:0] word);
    mem[addr[IDX_W+1:2]] = word;
  endtask

  // Background contents, every index bit shows up in the word
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = {~16'(i), 16'(i)} ^ 32'h5a5a_0000;
    end
  end

  assign cmd_next = {cmd_q[30:0], mosi_i};

  // mosi taken on rising sck, mode 0
  always @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      bit_cnt <= '0;
      cmd_q <= '0;
      rd_active <= 1'b0;
    end else begin
      if (bit_cnt < 7'd64) begin
        bit_cnt <= bit_cnt + 7'd1;
      end
      if (bit_cnt < 7'd32) begin
        cmd_q <= cmd_next;
      end
      // Last address bit in, look up the word
      if (bit_cnt == 7'd31) begin
        rd_active <= (cmd_next[31:24] == 8'h03);
        rd_word <= mem[cmd_next[IDX_W+1:2]];
      end
    end
  end

  // Data bits change on falling sck, first one right after the address
  always @(negedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      miso_o <= 1'b0;
    end else if (rd_active && bit_cnt >= 7'd32 && bit_cnt < 7'd64) begin
      miso_o <= rd_word[7'd63 - bit_cnt];
    end else begin
      miso_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_spi_xip_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_xip_top;

  localparam time CLK_PERIOD = 10ns;
  localparam int CYCLES_PER_STEP = 5000;
  localparam string GOLDEN_FILE = "test/spi_xip_golden.txt";

  typedef enum logic [2:0] {
    STEP_FLASH,
    STEP_WRITE,
    STEP_READ,
    STEP_XIP,
    STEP_BADADDR,
    STEP_IRQ,
    STEP_IRQWAIT
  } step_kind_e;

  // One golden line
  typedef struct packed {
    step_kind_e kind;
    logic [15:0] line_no;
    spi_xip_pkg::apb_addr_t addr;
    spi_xip_pkg::data_t wdata;
    spi_xip_pkg::strb_t strb;
    spi_xip_pkg::data_t expected;
  } golden_step_t;

  logic clock;
  logic reset;
  spi_xip_pkg::apb_addr_t paddr;
  logic psel;
  logic penable;
  logic pwrite;
  spi_xip_pkg::data_t pwdata;
  spi_xip_pkg::strb_t pstrb;
  logic pready;
  spi_xip_pkg::data_t prdata;
  logic pslverr;
  logic spi_sck;
  spi_xip_pkg::ss_t spi_ss;
  logic spi_mosi;
  logic spi_miso;
  logic spi_irq;

  golden_step_t steps[$];
  int n_steps = 0;
  logic [31:0] rand_state;

  spi_xip_top i_spi_xip_top (
    .clock        (clock),
    .reset        (reset),
    .in_paddr_i   (paddr),
    .in_psel_i    (psel),
    .in_penable_i (penable),
    .in_pwrite_i  (pwrite),
    .in_pwdata_i  (pwdata),
    .in_pstrb_i   (pstrb),
    .in_pready_o  (pready),
    .in_prdata_o  (prdata),
    .in_pslverr_o (pslverr),
    .spi_sck_o    (spi_sck),
    .spi_ss_o     (spi_ss),
    .spi_mosi_o   (spi_mosi),
    .spi_miso_i   (spi_miso),
    .spi_irq_o    (spi_irq)
  );

  // Flash on select line 0
  spi_flash_model i_spi_flash_model (
    .sck_i  (spi_sck),
    .ss_n_i (spi_ss[0]),
    .mosi_i (spi_mosi),
    .miso_o (spi_miso)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input spi_xip_pkg::data_t expected,
                            input spi_xip_pkg::data_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  task automatic check_ss(input string name, input spi_xip_pkg::ss_t expected,
                          input spi_xip_pkg::ss_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s expected %02h actual %02h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s expected %0b actual %0b", name, expected, actual));
    end
  endtask

  // Starts right after a rising edge, ends one ns after the completing edge
  task automatic apb_transfer(input spi_xip_pkg::apb_addr_t addr, input logic write,
                              input spi_xip_pkg::data_t wdata, input spi_xip_pkg::strb_t strb,
                              output spi_xip_pkg::data_t rdata, output logic slverr);
    // Setup phase
    paddr = addr;
    pwrite = write;
    pwdata = wdata;
    pstrb = write ? strb : 4'h0;
    psel = 1'b1;
    penable = 1'b0;
    @(posedge clock);
    #1;
    penable = 1'b1;
    // pready looked at mid cycle
    @(negedge clock);
    while (pready !== 1'b1) begin
      @(negedge clock);
    end
    rdata = prdata;
    slverr = pslverr;
    @(posedge clock);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_irq(input string name);
    int cycles;
    cycles = 0;
    while (spi_irq !== 1'b1 && cycles < CYCLES_PER_STEP) begin
      @(posedge clock);
      #1;
      cycles++;
    end
    if (spi_irq !== 1'b1) begin
      abort_run($sformatf("%s: interrupt did not rise after the transfer", name));
    end
  endtask

  task automatic load_golden();
    int fd;
    int n;
    int line_no;
    string text;
    string kind;
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] s;
    logic [31:0] e;
    golden_step_t cur;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("Cannot open %s", GOLDEN_FILE));
    end else begin
      line_no = 0;
      while (!$feof(fd)) begin
        text = "";
        n = $fgets(text, fd);
        line_no++;
        // Blank lines and comments
        if (n == 0 || text.len() < 2 || text[0] == "#") begin
          continue;
        end
        n = $sscanf(text, "%s %h %h %h %h", kind, a, w, s, e);
        if (n != 5) begin
          abort_run($sformatf("Golden line %0d does not have five fields", line_no));
        end
        case (kind)
          "FLASH": cur.kind = STEP_FLASH;
          "WRITE": cur.kind = STEP_WRITE;
          "READ": cur.kind = STEP_READ;
          "XIP": cur.kind = STEP_XIP;
          "BADADDR": cur.kind = STEP_BADADDR;
          "IRQ": cur.kind = STEP_IRQ;
          "IRQWAIT": cur.kind = STEP_IRQWAIT;
          default: abort_run($sformatf("Unknown kind %s on golden line %0d", kind, line_no));
        endcase
        cur.line_no = 16'(line_no);
        cur.addr = a;
        cur.wdata = w;
        cur.strb = s[3:0];
        cur.expected = e;
        steps.push_back(cur);
      end
      $fclose(fd);
      if (steps.size() == 0) begin
        abort_run("Golden file holds no steps");
      end
      n_steps = steps.size();
    end
  endtask

  task automatic run_step(input golden_step_t cur);
    string name;
    spi_xip_pkg::data_t rdata;
    logic slverr;
    name = $sformatf("line %0d %s", cur.line_no, cur.kind.name());
    case (cur.kind)
      STEP_FLASH: begin
        i_spi_flash_model.load_word(cur.addr[23:0], cur.wdata);
      end
      STEP_WRITE: begin
        apb_transfer(cur.addr, 1'b1, cur.wdata, cur.strb, rdata, slverr);
        check_flag(name, 1'b0, slverr);
        // Select pads are the inverse of the written select
        if (cur.addr[4:0] == spi_xip_pkg::REG_SS && cur.strb[0]) begin
          check_ss(name, ~spi_xip_pkg::ss_t'(cur.wdata), spi_ss);
        end
      end
      STEP_READ: begin
        apb_transfer(cur.addr, 1'b0, '0, '0, rdata, slverr);
        check_flag(name, 1'b0, slverr);
        check_data(name, cur.expected, rdata);
      end
      STEP_XIP: begin
        apb_transfer(cur.addr, 1'b0, '0, '0, rdata, slverr);
        check_flag(name, 1'b0, slverr);
        check_data(name, cur.expected, rdata);
        // Select released once the read is back
        check_ss(name, '1, spi_ss);
      end
      STEP_BADADDR: begin
        apb_transfer(cur.addr, 1'b0, '0, '0, rdata, slverr);
        check_flag(name, cur.expected[0], slverr);
      end
      STEP_IRQ: begin
        check_flag(name, cur.expected[0], spi_irq);
      end
      default: begin
        wait_irq(name);
      end
    endcase
  endtask

  initial begin
    int gap;
    logic prev_xip;
    logic pair_toggle;
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    pstrb = '0;
    rand_state = 32'h73ec_6ee1;
    prev_xip = 1'b0;
    pair_toggle = 1'b0;
    load_golden();
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    foreach (steps[i]) begin
      if (steps[i].kind inside {STEP_WRITE, STEP_READ, STEP_XIP, STEP_BADADDR}) begin
        rand_state = xorshift32(rand_state);
        gap = int'(rand_state[1:0]);
        // Every other XIP pair runs back to back
        if (steps[i].kind == STEP_XIP && prev_xip) begin
          pair_toggle = !pair_toggle;
          if (pair_toggle) begin
            gap = 0;
          end
        end
        repeat (gap) begin
          @(posedge clock);
          #1;
        end
      end
      run_step(steps[i]);
      prev_xip = (steps[i].kind == STEP_XIP);
    end
    $display("All tests passed");
    $finish;
  end

  // Watchdog, budget grows with the number of golden lines
  initial begin
    wait (n_steps > 0);
    repeat (CYCLES_PER_STEP * n_steps) @(posedge clock);
    abort_run($sformatf("Run hung, not finished after %0d cycles", CYCLES_PER_STEP * n_steps));
  end

endmodule

`default_nettype wire

// File: test/spi_xip_golden.txt
# kind address wdata strb expected, all hex
# FLASH address is a flash byte offset; IRQ and IRQWAIT look at the interrupt pin
FLASH 00000000 1234abcd 0 00000000
FLASH 00000004 deadbeef 0 00000000
FLASH 00000008 0f1e2d3c 0 00000000
FLASH 00000010 a5c39617 0 00000000
FLASH 00000ffc 80000001 0 00000000
BADADDR 20000000 00000000 0 00000001
READ 10001014 00000000 0 00000000
WRITE 10001014 00001234 f 00000000
READ 10001014 00000000 0 00001234
WRITE 10001014 ffff56ab 1 00000000
READ 10001014 00000000 0 000012ab
WRITE 10001018 00000001 f 00000000
READ 10001018 00000000 0 00000001
BADADDR 10001008 00000000 0 00000001
WRITE 10001018 00000000 f 00000000
XIP 30000000 00000000 0 1234abcd
XIP 30000004 00000000 0 deadbeef
XIP 30000010 00000000 0 a5c39617
XIP 30000008 00000000 0 0f1e2d3c
XIP 30000ffc 00000000 0 80000001
XIP 30000000 00000000 0 1234abcd
READ 10001014 00000000 0 00000001
READ 10001018 00000000 0 00000000
WRITE 10001004 03000010 f 00000000
WRITE 10001014 00000002 f 00000000
WRITE 10001018 00000001 f 00000000
WRITE 10001010 00001140 f 00000000
IRQWAIT 00000000 00000000 0 00000001
READ 10001000 00000000 0 a5c39617
IRQ 00000000 00000000 0 00000001
READ 10001010 00000000 0 00001040
IRQ 00000000 00000000 0 00000000
WRITE 10001018 00000000 f 00000000
BADADDR 50000000 00000000 0 00000001
READ 10001014 00000000 0 00000002
XIP 30000004 00000000 0 deadbeef
READ 10001018 00000000 0 00000000

// File: spi_xip_top.f
+incdir+include
hw/spi_xip_pkg.sv
hw/spi_shift_engine.sv
hw/spi_reg_bank.sv
hw/spi_apb_bridge.sv
hw/spi_xip_top.sv
test/spi_flash_model.sv
test/tb_spi_xip_top.sv

// File: Bender.yml
package:
  name: spi_xip

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/spi_xip_pkg.sv
      - hw/spi_shift_engine.sv
      - hw/spi_reg_bank.sv
      - hw/spi_apb_bridge.sv
      - hw/spi_xip_top.sv
  - target: test
    files:
      - test/spi_flash_model.sv
      - test/tb_spi_xip_top.sv
